//--- design/rv_isa_pkg.sv
// RV32I instruction set definitions shared by the execute stage
// data width, register numbers, ALU operations, branch kinds and
// operand forwarding sources
`default_nettype none

package rv_isa_pkg;

	localparam int xlen = 32;

	typedef logic [4:0] reg_idx_t;

	typedef enum logic [3:0] {
		alu_add    = 4'd0,
		alu_sub    = 4'd1,
		alu_sll    = 4'd2,
		alu_slt    = 4'd3,
		alu_sltu   = 4'd4,
		alu_xor    = 4'd5,
		alu_srl    = 4'd6,
		alu_sra    = 4'd7,
		alu_or     = 4'd8,
		alu_and    = 4'd9,
		alu_pass_b = 4'd10
	} alu_op_t;

	// jal is taken unconditionally, target is pc plus immediate
	typedef enum logic [2:0] {
		brch_none = 3'd0,
		brch_beq  = 3'd1,
		brch_bne  = 3'd2,
		brch_blt  = 3'd3,
		brch_bge  = 3'd4,
		brch_bltu = 3'd5,
		brch_bgeu = 3'd6,
		brch_jal  = 3'd7
	} brch_type_t;

	typedef enum logic [1:0] {
		fwd_reg_file = 2'd0,
		fwd_from_mem = 2'd1,
		fwd_from_wb  = 2'd2
	} fwd_sel_t;

endpackage

`default_nettype wire

//--- design/exe_pipe_pkg.sv
// Payload layouts of the two stage registers around execute
// ID/EX carries the decoded instruction, EX/MEM the execute result
`default_nettype none

package exe_pipe_pkg;

	import rv_isa_pkg::*;

	// pc holds pc+4 of the instruction, as decode hands it over
	typedef struct packed {
		logic             valid;
		logic [xlen-1:0]  srca;
		logic [xlen-1:0]  srcb;
		reg_idx_t         rs1;
		reg_idx_t         rs2;
		reg_idx_t         rd;
		logic [xlen-1:0]  pc;
		logic [xlen-1:0]  imm;
		logic             use_imm;
		alu_op_t          alu_op;
		brch_type_t       brch_type;
		logic [1:0]       be_mem;
		logic             we_mem;
		logic             we_reg;
		logic             mem_read;
	} id_ex_t;

	typedef struct packed {
		logic             valid;
		logic [xlen-1:0]  result;
		logic [xlen-1:0]  store_data;
		reg_idx_t         rd;
		logic [1:0]       be_mem;
		logic             we_mem;
		logic             we_reg;
		logic             mem_read;
	} ex_mem_t;

endpackage

`default_nettype wire

//--- design/pipe_stage_reg.sv
// Generic pipeline stage register
// clear inserts an all-zero bubble and wins over hold, hold keeps
// the stored payload, otherwise d is loaded on every rising edge
`default_nettype none

module pipe_stage_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     clear,
	input  logic     hold,
	input  payload_t d,
	output payload_t q
);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			q <= '0;
		end else if (clear) begin
			q <= '0;
		end else if (!hold) begin
			q <= d;
		end
	end

endmodule

`default_nettype wire

//--- design/exe_pipe_ctrl.sv
// Execute stage pipeline control
// load-use detection, memory back-pressure, redirect gating and the
// forwarding selects for both ALU operands
`default_nettype none

module exe_pipe_ctrl import rv_isa_pkg::*; (
	input  logic     id_valid,
	input  reg_idx_t id_rs1,
	input  reg_idx_t id_rs2,
	input  logic     ex_valid,
	input  logic     ex_mem_read,
	input  reg_idx_t ex_rd,
	input  reg_idx_t ex_rs1,
	input  reg_idx_t ex_rs2,
	input  logic     ex_taken,
	input  logic     mem_valid,
	input  logic     mem_we_reg,
	input  logic     mem_read,
	input  reg_idx_t mem_rd,
	input  logic     wb_we,
	input  reg_idx_t wb_rd,
	input  logic     mem_busy,
	output logic     id_ready,
	output logic     id_ex_clear,
	output logic     id_ex_hold,
	output logic     ex_mem_hold,
	output logic     redirect_valid,
	output fwd_sel_t fwd_a,
	output fwd_sel_t fwd_b
);

	logic load_use;
	logic mem_fwd_ok;
	logic wb_fwd_ok;

	function automatic fwd_sel_t pick_src(
		input reg_idx_t rs,
		input logic     m_ok,
		input reg_idx_t m_rd,
		input logic     w_ok,
		input reg_idx_t w_rd
	);
		if (m_ok && (m_rd == rs)) begin
			return fwd_from_mem;
		end else if (w_ok && (w_rd == rs)) begin
			return fwd_from_wb;
		end
		return fwd_reg_file;
	endfunction

	// ##########################################################################
	// stall, flush and bubble
	// ##########################################################################

	// the loaded value only exists at writeback, so the consumer waits a cycle
	assign load_use = id_valid && ex_valid && ex_mem_read && (ex_rd != '0) &&
		((ex_rd == id_rs1) || (ex_rd == id_rs2));

	// a taken branch redirects only once memory accepts again
	assign redirect_valid = ex_taken && !mem_busy;

	assign ex_mem_hold = mem_busy;
	assign id_ex_hold  = mem_busy;
	assign id_ex_clear = !mem_busy && (load_use || redirect_valid);
	assign id_ready    = !mem_busy && !load_use && !redirect_valid;

	// ##########################################################################
	// forwarding, EX/MEM before writeback
	// ##########################################################################

	// loads never forward from EX/MEM, their data is not there yet
	assign mem_fwd_ok = mem_valid && mem_we_reg && !mem_read && (mem_rd != '0);
	assign wb_fwd_ok  = wb_we && (wb_rd != '0);

	assign fwd_a = pick_src(ex_rs1, mem_fwd_ok, mem_rd, wb_fwd_ok, wb_rd);
	assign fwd_b = pick_src(ex_rs2, mem_fwd_ok, mem_rd, wb_fwd_ok, wb_rd);

endmodule

`default_nettype wire

//--- design/exe_operand_sel.sv
// Operand selection for the ALU
// applies the forwarding selects to both register values and picks
// the immediate for the second operand when asked
`default_nettype none

module exe_operand_sel import rv_isa_pkg::*; (
	input  logic [xlen-1:0] srca,
	input  logic [xlen-1:0] srcb,
	input  logic [xlen-1:0] imm,
	input  logic [xlen-1:0] mem_result,
	input  logic [xlen-1:0] wb_data,
	input  logic            use_imm,
	input  fwd_sel_t        fwd_a,
	input  fwd_sel_t        fwd_b,
	output logic [xlen-1:0] op_a,
	output logic [xlen-1:0] op_b,
	output logic [xlen-1:0] store_data
);

	logic [xlen-1:0] rs2_val;

	function automatic logic [xlen-1:0] fwd_mux(
		input fwd_sel_t        sel,
		input logic [xlen-1:0] reg_val,
		input logic [xlen-1:0] mem_val,
		input logic [xlen-1:0] wb_val
	);
		case (sel)
			fwd_from_mem: return mem_val;
			fwd_from_wb:  return wb_val;
			default:      return reg_val;
		endcase
	endfunction

	assign op_a    = fwd_mux(fwd_a, srca, mem_result, wb_data);
	assign rs2_val = fwd_mux(fwd_b, srcb, mem_result, wb_data);

	// stores and branches still need rs2 when the ALU takes the immediate
	assign op_b       = use_imm ? imm : rs2_val;
	assign store_data = rs2_val;

endmodule

`default_nettype wire

//--- design/exe_alu.sv
// Integer ALU for the RV32I register and immediate operations
// purely combinational, shifts take the low five bits of op_b
`default_nettype none

module exe_alu import rv_isa_pkg::*; (
	input  logic [xlen-1:0] op_a,
	input  logic [xlen-1:0] op_b,
	input  alu_op_t         alu_op,
	output logic [xlen-1:0] result
);

	logic [4:0] shamt;

	assign shamt = op_b[4:0];

	always_comb begin
		case (alu_op)
			alu_add: begin
				result = op_a + op_b;
			end
			alu_sub: begin
				result = op_a - op_b;
			end
			alu_sll: begin
				result = op_a << shamt;
			end
			alu_slt: begin
				result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			end
			alu_sltu: begin
				result = {{(xlen-1){1'b0}}, op_a < op_b};
			end
			alu_xor: begin
				result = op_a ^ op_b;
			end
			alu_srl: begin
				result = op_a >> shamt;
			end
			alu_sra: begin
				result = $unsigned($signed(op_a) >>> shamt);
			end
			alu_or: begin
				result = op_a | op_b;
			end
			alu_and: begin
				result = op_a & op_b;
			end
			alu_pass_b: begin
				result = op_b;
			end
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- design/exe_branch_unit.sv
// Branch resolution in execute
// compares the forwarded operands by branch type and reports the target,
// holding the last target between redirects
`default_nettype none

module exe_branch_unit import rv_isa_pkg::*; #(
	parameter logic [xlen-1:0] reset_pc = '0
) (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            valid,
	input  logic [xlen-1:0] rs1_val,
	input  logic [xlen-1:0] rs2_val,
	input  logic [xlen-1:0] pc,
	input  logic [xlen-1:0] imm,
	input  brch_type_t      brch_type,
	output logic            taken,
	output logic [xlen-1:0] redirect_pc
);

	logic            cond;
	logic [xlen-1:0] target;
	logic [xlen-1:0] last_target;

	always_comb begin
		case (brch_type)
			brch_beq:  cond = (rs1_val == rs2_val);
			brch_bne:  cond = (rs1_val != rs2_val);
			brch_blt:  cond = ($signed(rs1_val) < $signed(rs2_val));
			brch_bge:  cond = ($signed(rs1_val) >= $signed(rs2_val));
			brch_bltu: cond = (rs1_val < rs2_val);
			brch_bgeu: cond = (rs1_val >= rs2_val);
			brch_jal:  cond = 1'b1;
			default:   cond = 1'b0;
		endcase
	end

	assign taken = valid && cond;

	// pc arrives as pc+4 from decode
	assign target = pc - xlen'(4) + imm;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			last_target <= reset_pc;
		end else if (taken) begin
			last_target <= target;
		end
	end

	assign redirect_pc = taken ? target : last_target;

endmodule

`default_nettype wire

//--- design/exe_stage_top.sv
// Execute stage of the integer pipeline
// ID/EX register, operand forwarding, ALU, branch resolution and the
// EX/MEM register, under one control block
`default_nettype none

module exe_stage_top import rv_isa_pkg::*; import exe_pipe_pkg::*; #(
	parameter logic [xlen-1:0] reset_pc = '0
) (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            id_valid,
	input  logic [xlen-1:0] id_srca,
	input  logic [xlen-1:0] id_srcb,
	input  reg_idx_t        id_rs1,
	input  reg_idx_t        id_rs2,
	input  reg_idx_t        id_rd,
	input  logic [xlen-1:0] id_pc,
	input  logic [xlen-1:0] id_imm,
	input  logic            id_use_imm,
	input  alu_op_t         id_alu_op,
	input  brch_type_t      id_brch_type,
	input  logic [1:0]      id_be_mem,
	input  logic            id_we_mem,
	input  logic            id_we_reg,
	input  logic            id_mem_read,
	output logic            id_ready,
	output logic            mem_valid,
	output logic [xlen-1:0] mem_result,
	output logic [xlen-1:0] mem_store_data,
	output reg_idx_t        mem_rd,
	output logic [1:0]      mem_be,
	output logic            mem_we_mem,
	output logic            mem_we_reg,
	output logic            mem_read,
	input  logic            mem_busy,
	input  logic            wb_we,
	input  reg_idx_t        wb_rd,
	input  logic [xlen-1:0] wb_data,
	output logic            redirect_valid,
	output logic [xlen-1:0] redirect_pc
);

	id_ex_t          id_ex_in;
	id_ex_t          id_ex_refresh;
	id_ex_t          id_ex_d;
	id_ex_t          id_ex_q;
	ex_mem_t         ex_mem_d;
	ex_mem_t         ex_mem_q;
	logic            id_ex_clear;
	logic            id_ex_hold;
	logic            ex_mem_hold;
	logic            ex_taken;
	fwd_sel_t        fwd_a;
	fwd_sel_t        fwd_b;
	logic [xlen-1:0] op_a;
	logic [xlen-1:0] op_b;
	logic [xlen-1:0] store_data;
	logic [xlen-1:0] alu_result;

	// ##########################################################################
	// ID/EX
	// ##########################################################################

	assign id_ex_in = '{valid: id_valid, srca: id_srca, srcb: id_srcb,
		rs1: id_rs1, rs2: id_rs2, rd: id_rd, pc: id_pc, imm: id_imm,
		use_imm: id_use_imm, alu_op: id_alu_op, brch_type: id_brch_type,
		be_mem: id_be_mem, we_mem: id_we_mem, we_reg: id_we_reg,
		mem_read: id_mem_read};

	// while stalled the forwarded operands are written back into ID/EX,
	// a writeback value may be gone by the time the stall ends
	assign id_ex_refresh = '{valid: id_ex_q.valid, srca: op_a, srcb: store_data,
		rs1: id_ex_q.rs1, rs2: id_ex_q.rs2, rd: id_ex_q.rd, pc: id_ex_q.pc,
		imm: id_ex_q.imm, use_imm: id_ex_q.use_imm, alu_op: id_ex_q.alu_op,
		brch_type: id_ex_q.brch_type, be_mem: id_ex_q.be_mem,
		we_mem: id_ex_q.we_mem, we_reg: id_ex_q.we_reg,
		mem_read: id_ex_q.mem_read};

	assign id_ex_d = id_ex_hold ? id_ex_refresh : id_ex_in;

	pipe_stage_reg #(.payload_t(id_ex_t)) u_id_ex (
		.clk    (clk),
		.arst_n (arst_n),
		.clear  (id_ex_clear),
		.hold   (1'b0),
		.d      (id_ex_d),
		.q      (id_ex_q)
	);

	exe_pipe_ctrl u_ctrl (
		.id_valid       (id_valid),
		.id_rs1         (id_rs1),
		.id_rs2         (id_rs2),
		.ex_valid       (id_ex_q.valid),
		.ex_mem_read    (id_ex_q.mem_read),
		.ex_rd          (id_ex_q.rd),
		.ex_rs1         (id_ex_q.rs1),
		.ex_rs2         (id_ex_q.rs2),
		.ex_taken       (ex_taken),
		.mem_valid      (ex_mem_q.valid),
		.mem_we_reg     (ex_mem_q.we_reg),
		.mem_read       (ex_mem_q.mem_read),
		.mem_rd         (ex_mem_q.rd),
		.wb_we          (wb_we),
		.wb_rd          (wb_rd),
		.mem_busy       (mem_busy),
		.id_ready       (id_ready),
		.id_ex_clear    (id_ex_clear),
		.id_ex_hold     (id_ex_hold),
		.ex_mem_hold    (ex_mem_hold),
		.redirect_valid (redirect_valid),
		.fwd_a          (fwd_a),
		.fwd_b          (fwd_b)
	);

	// ##########################################################################
	// execute datapath
	// ##########################################################################

	exe_operand_sel u_operand_sel (
		.srca       (id_ex_q.srca),
		.srcb       (id_ex_q.srcb),
		.imm        (id_ex_q.imm),
		.mem_result (ex_mem_q.result),
		.wb_data    (wb_data),
		.use_imm    (id_ex_q.use_imm),
		.fwd_a      (fwd_a),
		.fwd_b      (fwd_b),
		.op_a       (op_a),
		.op_b       (op_b),
		.store_data (store_data)
	);

	exe_alu u_alu (
		.op_a   (op_a),
		.op_b   (op_b),
		.alu_op (id_ex_q.alu_op),
		.result (alu_result)
	);

	exe_branch_unit #(.reset_pc(reset_pc)) u_branch (
		.clk         (clk),
		.arst_n      (arst_n),
		.valid       (id_ex_q.valid),
		.rs1_val     (op_a),
		.rs2_val     (store_data),
		.pc          (id_ex_q.pc),
		.imm         (id_ex_q.imm),
		.brch_type   (id_ex_q.brch_type),
		.taken       (ex_taken),
		.redirect_pc (redirect_pc)
	);

	// ##########################################################################
	// EX/MEM
	// ##########################################################################

	// jal links pc+4 into rd, everything else takes the ALU result
	assign ex_mem_d = '{valid: id_ex_q.valid,
		result: (id_ex_q.brch_type == brch_jal) ? id_ex_q.pc : alu_result,
		store_data: store_data, rd: id_ex_q.rd, be_mem: id_ex_q.be_mem,
		we_mem: id_ex_q.we_mem, we_reg: id_ex_q.we_reg,
		mem_read: id_ex_q.mem_read};

	pipe_stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
		.clk    (clk),
		.arst_n (arst_n),
		.clear  (1'b0),
		.hold   (ex_mem_hold),
		.d      (ex_mem_d),
		.q      (ex_mem_q)
	);

	assign mem_valid      = ex_mem_q.valid;
	assign mem_result     = ex_mem_q.result;
	assign mem_store_data = ex_mem_q.store_data;
	assign mem_rd         = ex_mem_q.rd;
	assign mem_be         = ex_mem_q.be_mem;
	assign mem_we_mem     = ex_mem_q.we_mem;
	assign mem_we_reg     = ex_mem_q.we_reg;
	assign mem_read       = ex_mem_q.mem_read;

endmodule

`default_nettype wire

//--- testbench/exe_stage_props.sv
// Protocol properties of the execute stage
// redirect gating, load-use stall length and memory back-pressure
`default_nettype none

module exe_stage_props import rv_isa_pkg::*; (
	input wire logic            clk,
	input wire logic            arst_n,
	input wire logic            mem_busy,
	input wire logic            redirect_valid,
	input wire logic            id_ready,
	input wire logic            mem_valid,
	input wire logic [xlen-1:0] mem_result,
	input wire logic [xlen-1:0] mem_store_data,
	input wire reg_idx_t        mem_rd,
	input wire logic [1:0]      mem_be,
	input wire logic            mem_we_mem,
	input wire logic            mem_we_reg,
	input wire logic            mem_read
);

	timeunit 1ns;
	timeprecision 100ps;

	// a redirect waits for memory and flushes the branch out of execute
	redirect_not_busy: assert property (@(posedge clk) disable iff (!arst_n)
		redirect_valid |-> !mem_busy ##1 !redirect_valid)
		else $error("redirect raised while memory is busy or held past one cycle");

	// a load-use stall leaves a bubble behind, so it cannot repeat
	load_use_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
		(!id_ready && !mem_busy && !redirect_valid) |=> (mem_busy || id_ready))
		else $error("load-use stall longer than one cycle");

	mem_out_stable: assert property (@(posedge clk) disable iff (!arst_n)
		mem_busy |=> $stable({mem_valid, mem_result, mem_store_data, mem_rd,
			mem_be, mem_we_mem, mem_we_reg, mem_read}))
		else $error("memory outputs changed while memory is busy");

endmodule

bind exe_stage_top exe_stage_props u_props (
	.clk            (clk),
	.arst_n         (arst_n),
	.mem_busy       (mem_busy),
	.redirect_valid (redirect_valid),
	.id_ready       (id_ready),
	.mem_valid      (mem_valid),
	.mem_result     (mem_result),
	.mem_store_data (mem_store_data),
	.mem_rd         (mem_rd),
	.mem_be         (mem_be),
	.mem_we_mem     (mem_we_mem),
	.mem_we_reg     (mem_we_reg),
	.mem_read       (mem_read)
);

`default_nettype wire

//--- testbench/exe_stage_tb.sv
// Testbench for the execute stage
// plays decode, memory and writeback around the DUT, predicts results
// from an architectural register file and compares them in order
`default_nettype none

module exe_stage_tb import rv_isa_pkg::*;;

	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		logic [31:0] result;
		logic [31:0] store_data;
		logic [4:0]  rd;
		logic [1:0]  be;
		logic        we_reg;
		logic        we_mem;
		logic        mem_read;
	} exp_t;

	logic clk = 1'b0;
	logic arst_n;
	logic id_valid, id_use_imm, id_we_mem, id_we_reg, id_mem_read, id_ready;
	logic [31:0] id_srca, id_srcb, id_pc, id_imm;
	reg_idx_t id_rs1, id_rs2, id_rd;
	alu_op_t id_alu_op;
	brch_type_t id_brch_type;
	logic [1:0] id_be_mem, mem_be;
	logic mem_valid, mem_we_mem, mem_we_reg, mem_read, mem_busy, wb_we;
	logic [31:0] mem_result, mem_store_data, wb_data, redirect_pc;
	reg_idx_t mem_rd, wb_rd;
	logic redirect_valid;

	logic [31:0] lfsr = 32'd87;
	logic [31:0] aregs [32];
	logic [31:0] cregs [32];
	exp_t exp_q[$];
	logic [31:0] target_q[$];
	string cur_test = "reset";
	bit accepted, redirected, took_out;
	exp_t out_seen;
	logic [31:0] pc_next = 32'h100;
	int issued, stall_cnt;

	exe_stage_top #(.reset_pc(32'h0)) exe_stage_top_inst (.*);

	always #10 clk = ~clk;

	function logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic lsb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lsb = lfsr[0];
			lfsr = lfsr >> 1;
			if (lsb) begin
				lfsr = lfsr ^ 32'hA300_0000;
			end
			v = {v[30:0], lsb};
		end
		return v;
	endfunction

	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		return {addr[15:0], ~addr[31:16]} ^ (addr * 32'h0100_0193);
	endfunction

	// expected ALU result, written from the RV32I definitions
	function automatic logic [31:0] alu_ref(input alu_op_t op, input logic [31:0] a,
		input logic [31:0] b);
		case (op)
			alu_add:  return a + b;
			alu_sub:  return a - b;
			alu_sll:  return a << b[4:0];
			alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			alu_sltu: return (a < b) ? 32'd1 : 32'd0;
			alu_xor:  return a ^ b;
			alu_srl:  return a >> b[4:0];
			alu_sra:  return 32'($signed(a) >>> b[4:0]);
			alu_or:   return a | b;
			alu_and:  return a & b;
			default:  return b;
		endcase
	endfunction

	function automatic bit branch_ref(input brch_type_t t, input logic [31:0] a,
		input logic [31:0] b);
		case (t)
			brch_beq:  return a == b;
			brch_bne:  return a != b;
			brch_blt:  return $signed(a) < $signed(b);
			brch_bge:  return $signed(a) >= $signed(b);
			brch_bltu: return a < b;
			brch_bgeu: return a >= b;
			brch_jal:  return 1'b1;
			default:   return 1'b0;
		endcase
	endfunction

	task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
		assert (exp === act) else begin
			$display("ERROR %s %s: expected %h, actual %h", cur_test, what, exp, act);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic fail_with(input string why);
		$display("%s: %s", cur_test, why);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic new_instr(input logic [4:0] mask, input bit risky);
		logic [2:0] kind;
		logic [11:0] r;
		kind = rand_bits(3);
		r = rand_bits(12);
		id_rs1 = rand_bits(5) & mask;
		id_rs2 = rand_bits(5) & mask;
		id_rd = rand_bits(5) & mask;
		id_imm = rand_bits(1) ? {{20{r[11]}}, r} : rand_bits(32);
		id_use_imm = rand_bits(1);
		id_alu_op = alu_op_t'(4'(rand_bits(4) % 11));
		id_brch_type = brch_none;
		{id_we_reg, id_we_mem, id_mem_read, id_be_mem} = {3'b100, 2'b00};
		id_pc = pc_next + 32'd4;
		pc_next = pc_next + 32'd4;
		if (risky && kind >= 3'd5) begin
			id_alu_op = alu_add;
			id_use_imm = 1'b1;
			id_imm = {{20{r[11]}}, r};
			if (kind == 3'd5) begin
				{id_mem_read, id_be_mem} = 3'b111;
			end else if (kind == 3'd6 || rand_bits(1)) begin
				// conditional branch or jal, both take the offset as an even value
				id_use_imm = 1'b0;
				id_imm = {{19{r[11]}}, r, 1'b0};
				id_brch_type = (kind == 3'd6) ? brch_type_t'(3'(1 + rand_bits(3) % 6)) : brch_jal;
				id_we_reg = (id_brch_type == brch_jal);
				if (!id_we_reg) begin
					id_rd = '0;
				end
			end else begin
				{id_we_reg, id_we_mem, id_be_mem, id_rd} = {4'b0111, 5'd0};
			end
		end
	endtask

	// prediction from the architectural registers at acceptance
	task automatic record_expected();
		exp_t e;
		logic [31:0] a;
		logic [31:0] b;
		a = aregs[id_rs1];
		b = aregs[id_rs2];
		e.result = (id_brch_type == brch_jal) ? id_pc :
			alu_ref(id_alu_op, a, id_use_imm ? id_imm : b);
		e.store_data = b;
		e.rd = id_rd;
		e.be = id_be_mem;
		e.we_reg = id_we_reg;
		e.we_mem = id_we_mem;
		e.mem_read = id_mem_read;
		exp_q.push_back(e);
		if (id_we_reg && id_rd != 0) begin
			aregs[id_rd] = id_mem_read ? mem_word(e.result) : e.result;
		end
		if (branch_ref(id_brch_type, a, b)) begin
			target_q.push_back(id_pc - 32'd4 + id_imm);
		end
	endtask

	task automatic step_cycle(input bit gen, input int n, input logic [4:0] mask,
		input bit risky, input bit busy_on);
		@(posedge clk);
		#2;
		wb_we = took_out && out_seen.we_reg;
		wb_rd = out_seen.rd;
		wb_data = out_seen.mem_read ? mem_word(out_seen.result) : out_seen.result;
		if (wb_we && wb_rd != 0) begin
			cregs[wb_rd] = wb_data;
		end
		if (accepted || redirected) begin
			id_valid = 1'b0;
		end
		if (!id_valid && gen && issued < n && rand_bits(3) != 0) begin
			new_instr(mask, risky);
			id_valid = 1'b1;
			issued++;
		end
		// decode reads the register file again in every cycle it presents
		id_srca = cregs[id_rs1];
		id_srcb = cregs[id_rs2];
		mem_busy = busy_on && (rand_bits(2) == 0);
		@(negedge clk);
		accepted = id_valid && id_ready;
		redirected = redirect_valid;
		if (accepted) begin
			// a taken branch must redirect before anything younger gets in
			if (target_q.size() != 0) begin
				fail_with("instruction accepted behind a taken branch");
			end
			record_expected();
			stall_cnt = 0;
		end else if (id_valid && ++stall_cnt > 40) begin
			fail_with("decode was never accepted");
		end
		took_out = mem_valid && !mem_busy;
		out_seen = '{mem_result, mem_store_data, mem_rd, mem_be, mem_we_reg, mem_we_mem, mem_read};
		if (redirected) begin
			if (target_q.size() == 0) begin
				fail_with("redirect without a taken branch");
			end
			check_val("redirect_pc", target_q.pop_front(), redirect_pc);
		end
	endtask

	task automatic run_phase(input string name, input int n, input logic [4:0] mask,
		input bit risky, input bit busy_on);
		int cnt;
		cur_test = name;
		issued = 0;
		cnt = 0;
		while (issued < n || id_valid) begin
			step_cycle(1'b1, n, mask, risky, busy_on);
			if (++cnt > 40 * n) begin
				fail_with("instructions were not issued in time");
			end
		end
		cnt = 0;
		while (exp_q.size() != 0 || took_out) begin
			step_cycle(1'b0, n, mask, risky, 1'b0);
			if (++cnt > 100) begin
				fail_with("pipeline did not drain");
			end
		end
		check_val("pending redirects", 32'd0, target_q.size());
	endtask

	// in-order comparison of every output that memory takes
	always @(negedge clk) begin
		exp_t e;
		if (arst_n && mem_valid && !mem_busy) begin
			if (exp_q.size() == 0) begin
				fail_with("output without an accepted instruction");
			end
			e = exp_q.pop_front();
			check_val("mem_result", e.result, mem_result);
			check_val("mem_store_data", e.store_data, mem_store_data);
			check_val("mem_rd", e.rd, mem_rd);
			check_val("mem_be", e.be, mem_be);
			check_val("mem_we_reg", e.we_reg, mem_we_reg);
			check_val("mem_we_mem", e.we_mem, mem_we_mem);
			check_val("mem_read", e.mem_read, mem_read);
		end
	end

	initial begin
		arst_n = 1'b0;
		{id_valid, id_use_imm, id_we_mem, id_we_reg, id_mem_read, mem_busy, wb_we} = '0;
		{id_srca, id_srcb, id_pc, id_imm, wb_data} = '0;
		{id_rs1, id_rs2, id_rd, wb_rd, id_be_mem} = '0;
		id_alu_op = alu_add;
		id_brch_type = brch_none;
		out_seen = '0;
		for (int i = 0; i < 32; i++) begin
			aregs[i] = (i == 0) ? 32'd0 : rand_bits(32);
			cregs[i] = aregs[i];
		end
		repeat (3) @(posedge clk);
		#2 arst_n = 1'b1;
		@(negedge clk);
		check_val("mem_valid", 32'd0, mem_valid);
		check_val("redirect_valid", 32'd0, redirect_valid);
		check_val("id_ready", 32'd1, id_ready);
		run_phase("alu_random", 60, 5'h1f, 1'b0, 1'b0);
		run_phase("forwarding", 80, 5'h03, 1'b0, 1'b0);
		run_phase("load_branch", 120, 5'h07, 1'b1, 1'b0);
		run_phase("mem_busy", 150, 5'h07, 1'b1, 1'b1);
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
design/rv_isa_pkg.sv
design/exe_pipe_pkg.sv
design/pipe_stage_reg.sv
design/exe_pipe_ctrl.sv
design/exe_operand_sel.sv
design/exe_alu.sv
design/exe_branch_unit.sv
design/exe_stage_top.sv
testbench/exe_stage_props.sv
testbench/exe_stage_tb.sv

//--- Bender.yml
package:
  name: exe_stage

sources:
  - design/rv_isa_pkg.sv
  - design/exe_pipe_pkg.sv
  - design/pipe_stage_reg.sv
  - design/exe_pipe_ctrl.sv
  - design/exe_operand_sel.sv
  - design/exe_alu.sv
  - design/exe_branch_unit.sv
  - design/exe_stage_top.sv
  - target: test
    files:
      - testbench/exe_stage_props.sv
      - testbench/exe_stage_tb.sv
